// File: design/rv_isa_pkg.sv
// ****************************************
// ISA-level constants for the RV32 branch path
// opcode enum is internal to the EXU and not the RISC-V encoding
// instruction fetch assumes 4-byte alignment and no compressed ISA
// ****************************************
package rv_isa_pkg;

    localparam int XLEN            = 32;  // operand width
    localparam int INST_ADDR_WIDTH = 32;  // pc and target width
    localparam int INST_BYTES      = 4;   // step to the sequential pc

    // target must have these low bits clear for a legal fetch
    localparam int INST_ALIGN_BITS = 2;

    // jalr drops bit 0 of rs1+imm
    localparam logic [INST_ADDR_WIDTH-1:0] JALR_TARGET_MASK = ~INST_ADDR_WIDTH'(1);

    localparam int BJP_OP_WIDTH = 4;

    // branch unit opcodes
    // fence sits here too since it redirects like a jump
    typedef enum logic [BJP_OP_WIDTH-1:0] {
        BJP_NONE  = 4'd0,  // no branch work this cycle
        BJP_JAL   = 4'd1,  // already redirected by front end
        BJP_JALR  = 4'd2,
        BJP_BEQ   = 4'd3,
        BJP_BNE   = 4'd4,
        BJP_BLT   = 4'd5,  // signed
        BJP_BGE   = 4'd6,  // signed
        BJP_BLTU  = 4'd7,
        BJP_BGEU  = 4'd8,
        BJP_FENCE = 4'd9   // refetch from pc+4
    } bjp_op_e;

    // codes 10..15 are unused and decode as no branch

endpackage

// File: design/exu_pipe_pkg.sv
// ****************************************
// structs passed between the EXU branch stages
// request is one plain strobe per cycle, no handshake
// redirect is always accepted by fetch
// ****************************************
package exu_pipe_pkg;

    import rv_isa_pkg::*;

    // issued branch/jump/fence request
    typedef struct packed {
        logic                       valid;    // one-cycle strobe
        bjp_op_e                    op;
        logic [INST_ADDR_WIDTH-1:0] pc;       // pc of this instruction
        logic [XLEN-1:0]            rs1;
        logic [XLEN-1:0]            rs2;
        logic [XLEN-1:0]            imm;      // sign-extended offset
        logic                       is_pred;  // front end predicted taken
    } bjp_req_t;

    // operand unit results
    // flags compare rs1 against rs2
    typedef struct packed {
        logic                       eq;
        logic                       ge_signed;
        logic                       ge_unsigned;
        logic [INST_ADDR_WIDTH-1:0] adder_result;  // base + imm
        logic [INST_ADDR_WIDTH-1:0] next_pc;       // pc + 4
    } bjp_opnd_t;

    // redirect sent to the fetch unit
    typedef struct packed {
        logic                       valid;  // one cycle high
        logic [INST_ADDR_WIDTH-1:0] addr;   // only meaningful with valid
    } redirect_t;

endpackage

// File: design/exu_bjp_operand.sv
// ****************************************
// operand unit for branch resolution
// purely combinational, zero latency
// result fields are don't-care when req_i.valid is low
// ****************************************
module exu_bjp_operand (
    input  exu_pipe_pkg::bjp_req_t  req_i,
    output exu_pipe_pkg::bjp_opnd_t opnd_o
);

    import rv_isa_pkg::*;

    logic                       is_jalr;
    logic [INST_ADDR_WIDTH-1:0] adder_base;
    logic [INST_ADDR_WIDTH-1:0] adder_sum;
    logic [INST_ADDR_WIDTH-1:0] seq_pc;
    logic [XLEN-1:0]            op1;
    logic [XLEN-1:0]            op2;
    logic                       eq;
    logic                       ge_s;
    logic                       ge_u;

    assign op1 = req_i.rs1;
    assign op2 = req_i.rs2;

    // comparator flags
    // blt/bltu are the inverse of the ge flags
    assign eq   = (op1 == op2);
    assign ge_s = ($signed(op1) >= $signed(op2));  // two's complement order
    assign ge_u = (op1 >= op2);                    // plain magnitude

    // adder base select
    // jalr is register relative, everything else pc relative
    assign is_jalr = (req_i.op == BJP_JALR);

    always_comb begin
        if (is_jalr) begin
            adder_base = req_i.rs1;  // rs1 + imm
        end else begin
            adder_base = req_i.pc;   // pc + imm
        end
    end

    assign adder_sum = adder_base + req_i.imm;  // wraps at 2^32

    // sequential pc for fence and rollback
    assign seq_pc = req_i.pc + INST_ADDR_WIDTH'(INST_BYTES);

    // pack results
    always_comb begin
        opnd_o.eq           = eq;
        opnd_o.ge_signed    = ge_s;
        opnd_o.ge_unsigned  = ge_u;
        opnd_o.adder_result = adder_sum;
        opnd_o.next_pc      = seq_pc;
    end

    // note that the adder is shared between jalr and the pc-relative ops
    // so only one target is formed per cycle

endmodule

// File: design/exu_bru.sv
// ****************************************
// branch resolution unit
// combinational, zero latency
// JAL is only checked for alignment here
// interrupt masks the jump but not the misaligned flag
// ****************************************
module exu_bru (
    input  exu_pipe_pkg::bjp_req_t                 req_i,
    input  exu_pipe_pkg::bjp_opnd_t                opnd_i,
    input  logic                                   int_assert_i,
    input  logic [rv_isa_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    output logic                                   jump_flag_o,
    output logic [rv_isa_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                                   misaligned_fetch_o
);

    import rv_isa_pkg::*;

    logic                       branch_cond;  // op condition before valid gating
    logic                       cond_hit;
    logic                       is_jal;
    logic                       is_jalr;
    logic                       is_fence;
    logic                       pred_rollback;
    logic                       jump;
    logic                       misaligned;
    logic [INST_ADDR_WIDTH-1:0] jalr_target;
    logic [INST_ADDR_WIDTH-1:0] target;

    // condition per opcode
    always_comb begin
        unique case (req_i.op)
            BJP_BEQ:  branch_cond = opnd_i.eq;
            BJP_BNE:  branch_cond = ~opnd_i.eq;
            BJP_BLT:  branch_cond = ~opnd_i.ge_signed;
            BJP_BGE:  branch_cond = opnd_i.ge_signed;
            BJP_BLTU: branch_cond = ~opnd_i.ge_unsigned;
            BJP_BGEU: branch_cond = opnd_i.ge_unsigned;
            BJP_JALR: branch_cond = 1'b1;  // unconditional
            default:  branch_cond = 1'b0;  // none, jal, fence
        endcase
    end

    assign cond_hit = req_i.valid & branch_cond;
    assign is_jal   = req_i.valid & (req_i.op == BJP_JAL);
    assign is_jalr  = (req_i.op == BJP_JALR);
    assign is_fence = req_i.valid & (req_i.op == BJP_FENCE);

    // predicted taken but condition false
    assign pred_rollback = req_i.valid & req_i.is_pred & ~branch_cond;

    // predicted and taken needs nothing, fetch is already there
    assign jump = (cond_hit & ~req_i.is_pred) | is_fence | pred_rollback;

    assign jalr_target = opnd_i.adder_result & JALR_TARGET_MASK;

    // target select
    always_comb begin
        if (is_fence || pred_rollback) begin
            target = opnd_i.next_pc;  // sequential refetch
        end else if (is_jalr) begin
            target = jalr_target;
        end else begin
            target = opnd_i.adder_result;
        end
    end

    // low bits must be zero for a 4-byte fetch
    assign misaligned = (target[INST_ALIGN_BITS-1:0] != '0) && (jump || is_jal);

    // interrupt vector wins the address
    always_comb begin
        if (int_assert_i && req_i.valid) begin
            jump_addr_o = int_addr_i;
        end else begin
            jump_addr_o = target;
        end
    end

    assign misaligned_fetch_o = misaligned;
    assign jump_flag_o        = jump & ~misaligned & ~int_assert_i;  // trap or irq blocks it

endmodule

// File: design/exu_redirect.sv
// ****************************************
// redirect register and wrong-path squash
// one cycle latency, redirect held one cycle
// squashes exactly one request after a redirect
// ****************************************
module exu_redirect (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  exu_pipe_pkg::bjp_req_t                 req_i,
    output exu_pipe_pkg::bjp_req_t                 req_o,
    input  logic                                   jump_flag_i,
    input  logic [rv_isa_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                                   misaligned_i,
    output exu_pipe_pkg::redirect_t                redirect_o,
    output logic                                   misaligned_o
);

    logic squash;  // current slot is wrong path

    // a request arriving while the redirect is out came from the old path
    assign squash = redirect_o.valid;

    // pass the request through with valid masked
    always_comb begin
        req_o       = req_i;
        req_o.valid = req_i.valid & ~squash;
    end

    // output registers
    // addr is loaded every cycle, fetch only looks at it with valid
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            redirect_o.valid <= 1'b0;
            redirect_o.addr  <= '0;
            misaligned_o     <= 1'b0;
        end else begin
            redirect_o.valid <= jump_flag_i;   // one-cycle pulse
            redirect_o.addr  <= jump_addr_i;
            misaligned_o     <= misaligned_i;  // to trap logic
        end
    end

    // jump_flag_i is already low for a squashed slot since the bru
    // sees the masked valid, so the pulse cannot stretch past a cycle

endmodule

// File: design/exu_branch_top.sv
// ****************************************
// branch resolution top of the execute stage
// request at edge N gives redirect at edge N+1
// int_assert_i is a level sampled with the request
// ****************************************
module exu_branch_top (
    input  logic                                   clk_i,
    input  logic                                   rst_i,
    input  exu_pipe_pkg::bjp_req_t                 req_i,
    input  logic                                   int_assert_i,
    input  logic [rv_isa_pkg::INST_ADDR_WIDTH-1:0] int_addr_i,
    output exu_pipe_pkg::redirect_t                redirect_o,
    output logic                                   misaligned_o
);

    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    bjp_req_t                   req_flt;     // request after squash
    bjp_opnd_t                  opnd;
    logic                       jump_flag;
    logic [INST_ADDR_WIDTH-1:0] jump_addr;
    logic                       misaligned;

    // squash filter and output registers
    exu_redirect u_redirect (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .req_o        (req_flt),
        .jump_flag_i  (jump_flag),
        .jump_addr_i  (jump_addr),
        .misaligned_i (misaligned),
        .redirect_o   (redirect_o),
        .misaligned_o (misaligned_o)
    );

    // compare and target adder
    exu_bjp_operand u_operand (
        .req_i  (req_flt),
        .opnd_o (opnd)
    );

    // decide redirect
    exu_bru u_bru (
        .req_i              (req_flt),
        .opnd_i             (opnd),
        .int_assert_i       (int_assert_i),
        .int_addr_i         (int_addr_i),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr),
        .misaligned_fetch_o (misaligned)
    );

endmodule

// File: tb/tb_branch_vectors.svh
// ****************************************
// branch request rows, one per request cycle
// rows run back to back
// expected columns ignore the squash
// int_addr is only meaningful on rows with irq set
// ****************************************
`ifndef TB_BRANCH_VECTORS_SVH
`define TB_BRANCH_VECTORS_SVH

// one row of request plus expected result
typedef struct packed {
    bjp_req_t                   req;
    logic                       int_assert;
    logic [INST_ADDR_WIDTH-1:0] int_addr;
    logic                       exp_valid;
    logic [INST_ADDR_WIDTH-1:0] exp_addr;   // checked only with exp_valid
    logic                       exp_mis;
} vec_t;

localparam logic [INST_ADDR_WIDTH-1:0] IRQ_VEC = 32'h0000_0800;  // irq target

vec_t vecs[$];

task automatic add_vec(input int v, input bjp_op_e op, input logic [INST_ADDR_WIDTH-1:0] pc,
                       input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                       input logic [XLEN-1:0] imm, input int pred, input int irq,
                       input int exp_v, input logic [INST_ADDR_WIDTH-1:0] exp_addr,
                       input int exp_mis);
    vec_t e;
    e              = '0;
    e.req.valid    = (v != 0);
    e.req.op       = op;
    e.req.pc       = pc;
    e.req.rs1      = rs1;
    e.req.rs2      = rs2;
    e.req.imm      = imm;
    e.req.is_pred  = (pred != 0);
    e.int_assert   = (irq != 0);
    e.int_addr     = (irq != 0) ? IRQ_VEC : '0;
    e.exp_valid    = (exp_v != 0);
    e.exp_addr     = exp_addr;
    e.exp_mis      = (exp_mis != 0);
    vecs.push_back(e);
endtask

// column order is valid op pc rs1 rs2 imm pred irq then exp_valid exp_addr exp_mis
task automatic load_vectors();
    add_vec(1, BJP_BEQ,   32'h1000, 32'h5, 32'h5, 32'h40, 0, 0, 1, 32'h1040, 0);  // taken
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);          // bubble
    add_vec(1, BJP_BEQ,   32'h1100, 32'h5, 32'h6, 32'h40, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BNE,   32'h1200, 32'h5, 32'h6, 32'h80, 0, 0, 1, 32'h1280, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BNE,   32'h1300, 32'h7, 32'h7, 32'h8, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BLT,   32'h1400, 32'hFFFF_FFFF, 32'h1, 32'h10, 0, 0, 1, 32'h1410, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BLTU,  32'h1500, 32'hFFFF_FFFF, 32'h1, 32'h10, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BGE,   32'h1500, 32'hFFFF_FFFF, 32'h1, 32'h10, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BGEU,  32'h1600, 32'hFFFF_FFFF, 32'h1, 32'h20, 0, 0, 1, 32'h1620, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BLTU,  32'h1700, 32'h1, 32'hFFFF_FFFF, 32'h4, 0, 0, 1, 32'h1704, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BGEU,  32'h1780, 32'h1, 32'hFFFF_FFFF, 32'h4, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BGE,   32'h1800, 32'h3, 32'h3, 32'hFFFF_FFF0, 0, 0, 1, 32'h17F0, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BLT,   32'h1900, 32'h3, 32'h3, 32'h40, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BEQ,   32'h1A00, 32'h9, 32'h9, 32'h40, 1, 0, 0, 32'h0, 0);     // predicted ok
    add_vec(1, BJP_BNE,   32'h1B00, 32'h9, 32'h9, 32'h40, 1, 0, 1, 32'h1B04, 0);  // rollback
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_JALR,  32'h1C00, 32'h2001, 32'h0, 32'h10, 0, 0, 1, 32'h2010, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_FENCE, 32'h1D00, 32'h0, 32'h0, 32'h0, 0, 0, 1, 32'h1D04, 0);
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_NONE,  32'h1E00, 32'h0, 32'h0, 32'h40, 0, 0, 0, 32'h0, 0);
    add_vec(0, BJP_BEQ,   32'h1E80, 32'h5, 32'h5, 32'h40, 0, 0, 0, 32'h0, 0);     // not valid
    add_vec(1, BJP_BEQ,   32'h1F00, 32'h1, 32'h1, 32'h6, 0, 0, 0, 32'h0, 1);      // ends 10
    add_vec(1, BJP_JALR,  32'h2000, 32'h3000, 32'h0, 32'h2, 0, 0, 0, 32'h0, 1);
    add_vec(1, BJP_JAL,   32'h2100, 32'h0, 32'h0, 32'h102, 0, 0, 0, 32'h0, 1);
    add_vec(1, BJP_JAL,   32'h2200, 32'h0, 32'h0, 32'h100, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BEQ,   32'h2300, 32'h4, 32'h4, 32'h40, 0, 1, 0, 32'h0800, 0);  // irq masks
    add_vec(1, BJP_FENCE, 32'h2400, 32'h0, 32'h0, 32'h0, 0, 1, 0, 32'h0800, 0);
    add_vec(1, BJP_BNE,   32'h2500, 32'h1, 32'h2, 32'h40, 0, 0, 1, 32'h2540, 0);
    add_vec(1, BJP_FENCE, 32'h2600, 32'h0, 32'h0, 32'h0, 0, 0, 1, 32'h2604, 0);   // squashed
    add_vec(1, BJP_BEQ,   32'h2700, 32'h8, 32'h8, 32'h20, 0, 0, 1, 32'h2720, 0);
    add_vec(1, BJP_JALR,  32'h2780, 32'h4000, 32'h0, 32'h8, 0, 0, 1, 32'h4008, 0);  // squashed
    add_vec(1, BJP_FENCE, 32'h2800, 32'h0, 32'h0, 32'h0, 0, 0, 1, 32'h2804, 0);
    add_vec(1, BJP_BEQ,   32'h2900, 32'h1, 32'h1, 32'h6, 0, 1, 0, 32'h0800, 1);   // squashed
    add_vec(0, BJP_NONE,  32'h0, 32'h0, 32'h0, 32'h0, 0, 0, 0, 32'h0, 0);
    add_vec(1, BJP_BEQ,   32'h2A00, 32'h1, 32'h1, 32'h6, 0, 1, 0, 32'h0800, 1);   // irq keeps mis
endtask

`endif

// File: tb/tb_exu_branch.sv
// ****************************************
// testbench for exu_branch_top
// rows of tb_branch_vectors.svh run back to back
// then random bubbles with op none, no redirect allowed
// stops at the first mismatch
// ****************************************
module tb_exu_branch;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import exu_pipe_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;   // ns after the rising edge
    localparam int RST_CYCLES = 3;
    localparam int NUM_FILL   = 16;  // random rows after the table

    logic                       clk;
    logic                       rst;
    bjp_req_t                   req;
    logic                       int_assert;
    logic [INST_ADDR_WIDTH-1:0] int_addr;
    redirect_t                  redirect;
    logic                       misaligned;

    integer seed        = 32'h5134;
    int     err_count   = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 0;
    logic   prev_exp_valid;  // last expected redirect

    `include "tb_branch_vectors.svh"

    exu_branch_top DUT (
        .clk_i        (clk),
        .rst_i        (rst),
        .req_i        (req),
        .int_assert_i (int_assert),
        .int_addr_i   (int_addr),
        .redirect_o   (redirect),
        .misaligned_o (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display(">>> FAIL");
            $fatal(1, "timeout, the vector loop did not finish in %0d cycles", cycle_limit);
        end
    end

    task automatic check_value(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0d ns row %0d %s: got 0x%08h expected 0x%08h",
                     $time, idx, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive_row(input vec_t v);
        req        = v.req;
        int_assert = v.int_assert;
        int_addr   = v.int_addr;
    endtask

    // a row seen while a redirect is out is wrong path and gives nothing
    task automatic check_row(input int idx, input vec_t v);
        logic exp_v;
        logic exp_mis;
        exp_v   = v.exp_valid & ~prev_exp_valid;
        exp_mis = v.exp_mis & ~prev_exp_valid;  // squashed rows never trap
        check_value(idx, "redirect_o.valid", 32'(redirect.valid), 32'(exp_v));
        check_value(idx, "misaligned_o", 32'(misaligned), 32'(exp_mis));
        if (exp_v) begin
            check_value(idx, "redirect_o.addr", redirect.addr, v.exp_addr);
        end
        prev_exp_valid = exp_v;
    endtask

    // random op none rows with all expected fields zero
    task automatic add_filler(input int count);
        vec_t        e;
        logic [31:0] rnd;
        for (int k = 0; k < count; k++) begin
            e            = '0;
            rnd          = $random(seed);
            e.req.valid  = rnd[0];
            e.req.op     = BJP_NONE;
            e.req.pc     = $random(seed);
            e.req.rs1    = $random(seed);
            e.req.rs2    = $random(seed);
            e.req.imm    = $random(seed);
            e.int_assert = rnd[1];  // must not matter without a jump
            e.int_addr   = IRQ_VEC;
            vecs.push_back(e);
        end
    endtask

    initial begin
        vec_t idle_row;
        idle_row       = '0;
        int_assert     = 1'b0;
        int_addr       = '0;
        rst            = 1'b1;
        prev_exp_valid = 1'b0;

        // request held in reset would trap or redirect if it got through
        req       = '0;
        req.valid = 1'b1;
        req.op    = BJP_JAL;
        req.pc    = 32'h0000_0100;
        req.imm   = 32'h0000_0102;  // pc+imm ends in binary 10

        load_vectors();
        add_filler(NUM_FILL);
        cycle_limit = vecs.size() + 20;

        // outputs stay low through reset and straight after it
        for (int r = 0; r < RST_CYCLES; r++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (r == RST_CYCLES - 1) begin
                rst = 1'b0;
            end
            check_value(-1, "redirect_o.valid", 32'(redirect.valid), 32'h0);
            check_value(-1, "redirect_o.addr", redirect.addr, 32'h0);
            check_value(-1, "misaligned_o", 32'(misaligned), 32'h0);
            // swap between misaligned jal and fence
            if (req.op == BJP_JAL) begin
                req.op = BJP_FENCE;
            end else begin
                req.op = BJP_JAL;
            end
        end

        drive_row(vecs[0]);
        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_row(i, vecs[i]);  // result of the row sampled at this edge
            if (i + 1 < vecs.size()) begin
                drive_row(vecs[i + 1]);
            end else begin
                drive_row(idle_row);
            end
        end

        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+tb
design/rv_isa_pkg.sv
design/exu_pipe_pkg.sv
design/exu_bjp_operand.sv
design/exu_bru.sv
design/exu_redirect.sv
design/exu_branch_top.sv
tb/tb_exu_branch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the branch unit testbench with Verilator
# exits nonzero when the build fails or the run reports a failure

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sim_exu_branch
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_exu_branch \
    -Mdir "$OBJ_DIR" -o "$SIM_BIN" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0
